/* include/sdram_csr_cfg.svh */
`ifndef SDRAM_CSR_CFG_SVH
`define SDRAM_CSR_CFG_SVH

// --------------------------------------------------
// Clock and cycle conversion
// --------------------------------------------------
`define CSR_TCLK_PS 1000                                    // Clock period in ps

`define CSR_CEIL_DIV(num, den) (((num) + (den) - 1) / (den))
`define CSR_NS2CK_MIN(ns) `CSR_CEIL_DIV((ns) * 64'd1000, `CSR_TCLK_PS)  // Minimum, round up
`define CSR_NS2CK_MAX(ns) (((ns) * 64'd1000) / `CSR_TCLK_PS)           // Maximum, round down
`define CSR_MAX(a, b) (((a) > (b)) ? (a) : (b))

// --------------------------------------------------
// Register map
// --------------------------------------------------
`define CSR_ADDR_CTRL       32'h00
`define CSR_ADDR_OPMODE     32'h04
`define CSR_ADDR_CONFIG     32'h08
`define CSR_ADDR_T_DLY_RST  32'h20
`define CSR_ADDR_T_RASMIN   32'h64
`define CSR_ADDR_T_RASMAX   32'h68
`define CSR_ADDR_T_RC       32'h6c
`define CSR_ADDR_T_RCD      32'h70
`define CSR_ADDR_T_REF      32'h74
`define CSR_ADDR_T_RFC      32'h78
`define CSR_ADDR_T_REF_MIN  32'h7c
`define CSR_ADDR_T_RP       32'h80
`define CSR_ADDR_T_RRD      32'h84
`define CSR_ADDR_T_WRP      32'h88
`define CSR_ADDR_T_XSR      32'h8c
`define CSR_ADDR_T_DAL      32'ha0
`define CSR_ADDR_T_DPL      32'ha4
`define CSR_ADDR_T_MRD      32'hb8
`define CSR_ADDR_T_RDL      32'hc0

// --------------------------------------------------
// Timing field widths
// --------------------------------------------------
`define CSR_W_T_DLY_RST 20
`define CSR_W_T_RASMIN  8
`define CSR_W_T_RASMAX  20
`define CSR_W_T_RC      8
`define CSR_W_T_RCD     8
`define CSR_W_T_REF     20
`define CSR_W_T_RFC     8
`define CSR_W_T_REF_MIN 16                                  // 7813 needs 13 bits
`define CSR_W_T_RP      8
`define CSR_W_T_RRD     8
`define CSR_W_T_WRP     8
`define CSR_W_T_XSR     8
`define CSR_W_T_DAL     4
`define CSR_W_T_DPL     4
`define CSR_W_T_MRD     4
`define CSR_W_T_RDL     4

// --------------------------------------------------
// Reset cycle counts from datasheet figures in ns
// --------------------------------------------------
`define CSR_RST_T_DLY_RST `CSR_NS2CK_MIN(100_000)          // 100 us before first command
`define CSR_RST_T_RASMIN  `CSR_NS2CK_MIN(37)               // ACTIVE to PRECHARGE, min
`define CSR_RST_T_RASMAX  `CSR_NS2CK_MAX(120_000)          // ACTIVE to PRECHARGE, max
`define CSR_RST_T_RC      `CSR_NS2CK_MIN(60)               // ACTIVE to ACTIVE
`define CSR_RST_T_RCD     `CSR_NS2CK_MIN(15)               // ACTIVE to READ or WRITE
`define CSR_RST_T_REF     `CSR_NS2CK_MAX(64_000)           // Refresh counter period
`define CSR_RST_T_RFC     `CSR_NS2CK_MIN(66)               // AUTO REFRESH period
// One refresh per row, 8192 rows in 64 ms
`define CSR_RST_T_REF_MIN `CSR_CEIL_DIV(64'd64_000_000 * 64'd1000, 64'd8192 * `CSR_TCLK_PS)
`define CSR_RST_T_RP      `CSR_NS2CK_MIN(15)               // PRECHARGE period
`define CSR_RST_T_RRD     `CSR_NS2CK_MIN(14)               // Bank to bank ACTIVE
`define CSR_RST_T_WRP     `CSR_NS2CK_MIN(14)               // Write recovery
`define CSR_RST_T_XSR     `CSR_MAX(`CSR_NS2CK_MIN(67), 64'd2)  // Self refresh exit
`define CSR_RST_T_DAL     4                                 // Data-in to ACTIVE
`define CSR_RST_T_DPL     2                                 // Data-in to PRECHARGE
`define CSR_RST_T_MRD     2                                 // LOAD MODE to next command
`define CSR_RST_T_RDL     2                                 // Last data-in to PRECHARGE

`endif

/* src/sdram_csr_pkg.sv */
`include "sdram_csr_cfg.svh"

package sdram_csr_pkg;

    typedef logic [31:0] csr_word_t;                        // Bus data word

    // --------------------------------------------------
    // Mode register word
    // --------------------------------------------------
    typedef struct packed {
        logic [16:0] reserved;
        logic [1:0]  ba_reserved;
        logic [2:0]  a_reserved;
        logic        wr_burst_mode;
        logic [1:0]  operation_mode;
        logic [2:0]  cas_latency;
        logic        burst_type;                            // Sequential or interleaved
        logic [2:0]  burst_len;
    } csr_opmode_t;

    typedef union packed {
        csr_word_t   word;                                  // Bus write and read-back
        csr_opmode_t field;                                 // Decoded mode fields
    } csr_opmode_u;

    typedef struct packed {
        logic        start;
        logic        self_refresh;
        csr_opmode_t opmode;
        logic        prechg_after_rd;
        csr_word_t   ctrl_word;                             // Raw ctrl register
        csr_word_t   cfg_word;                              // Raw config register
    } csr_mode_t;

    // --------------------------------------------------
    // Timing values in clock cycles
    // --------------------------------------------------
    typedef struct packed {
        logic [`CSR_W_T_DLY_RST-1:0] t_dly_rst;
        logic [`CSR_W_T_RASMIN-1:0]  t_rasmin;
        logic [`CSR_W_T_RASMAX-1:0]  t_rasmax;
        logic [`CSR_W_T_RC-1:0]      t_rc;
        logic [`CSR_W_T_RCD-1:0]     t_rcd;
        logic [`CSR_W_T_REF-1:0]     t_ref;
        logic [`CSR_W_T_RFC-1:0]     t_rfc;
        logic [`CSR_W_T_REF_MIN-1:0] t_ref_min;
        logic [`CSR_W_T_RP-1:0]      t_rp;
        logic [`CSR_W_T_RRD-1:0]     t_rrd;
        logic [`CSR_W_T_WRP-1:0]     t_wrp;
        logic [`CSR_W_T_XSR-1:0]     t_xsr;
        logic [`CSR_W_T_DAL-1:0]     t_dal;
        logic [`CSR_W_T_DPL-1:0]     t_dpl;
        logic [`CSR_W_T_MRD-1:0]     t_mrd;
        logic [`CSR_W_T_RDL-1:0]     t_rdl;
    } csr_timing_t;

    // --------------------------------------------------
    // Decoded bus access
    // --------------------------------------------------
    typedef enum logic [1:0] {
        bank_none,
        bank_mode,
        bank_timing
    } csr_bank_e;

    typedef struct packed {
        logic      wr;                                      // One cycle write strobe
        csr_bank_e bank;
        logic [4:0] index;                                  // Register within bank
        csr_word_t wdata;
    } csr_sel_t;

    // Register numbers within each bank
    localparam logic [4:0] idx_ctrl      = 5'd0;
    localparam logic [4:0] idx_opmode    = 5'd1;
    localparam logic [4:0] idx_config    = 5'd2;

    localparam logic [4:0] idx_t_dly_rst = 5'd0;
    localparam logic [4:0] idx_t_rasmin  = 5'd1;
    localparam logic [4:0] idx_t_rasmax  = 5'd2;
    localparam logic [4:0] idx_t_rc      = 5'd3;
    localparam logic [4:0] idx_t_rcd     = 5'd4;
    localparam logic [4:0] idx_t_ref     = 5'd5;
    localparam logic [4:0] idx_t_rfc     = 5'd6;
    localparam logic [4:0] idx_t_ref_min = 5'd7;
    localparam logic [4:0] idx_t_rp      = 5'd8;
    localparam logic [4:0] idx_t_rrd     = 5'd9;
    localparam logic [4:0] idx_t_wrp     = 5'd10;
    localparam logic [4:0] idx_t_xsr     = 5'd11;
    localparam logic [4:0] idx_t_dal     = 5'd12;
    localparam logic [4:0] idx_t_dpl     = 5'd13;
    localparam logic [4:0] idx_t_mrd     = 5'd14;
    localparam logic [4:0] idx_t_rdl     = 5'd15;

endpackage

/* src/sdram_csr_bus.sv */
`timescale 1ns/1ns

`include "sdram_csr_cfg.svh"

module sdram_csr_bus #(
    parameter int addr_width = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [addr_width-1:0]    address,
    input  sdram_csr_pkg::csr_word_t writedata,
    input  logic                     strobe,
    input  logic                     cycle,
    input  logic                     write,
    input  sdram_csr_pkg::csr_word_t mode_rdata,
    input  sdram_csr_pkg::csr_word_t timing_rdata,
    output sdram_csr_pkg::csr_sel_t  sel,
    output sdram_csr_pkg::csr_word_t readdata,
    output logic                     ack
);

    import sdram_csr_pkg::*;

    logic      trans;
    logic      trans_dly;
    logic      trans_start;
    csr_word_t addr_word;
    csr_bank_e bank;
    logic [4:0] index;
    csr_word_t bank_rdata;

    assign trans       = strobe & cycle;
    assign trans_start = trans & ~trans_dly;                // First cycle only
    assign addr_word   = csr_word_t'(address);              // Full address compare

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    always_comb begin
        bank  = bank_mode;
        index = '0;
        case (addr_word)
            `CSR_ADDR_CTRL:   index = idx_ctrl;
            `CSR_ADDR_OPMODE: index = idx_opmode;
            `CSR_ADDR_CONFIG: index = idx_config;
            default: begin
                bank = bank_timing;
                case (addr_word)
                    `CSR_ADDR_T_DLY_RST: index = idx_t_dly_rst;
                    `CSR_ADDR_T_RASMIN:  index = idx_t_rasmin;
                    `CSR_ADDR_T_RASMAX:  index = idx_t_rasmax;
                    `CSR_ADDR_T_RC:      index = idx_t_rc;
                    `CSR_ADDR_T_RCD:     index = idx_t_rcd;
                    `CSR_ADDR_T_REF:     index = idx_t_ref;
                    `CSR_ADDR_T_RFC:     index = idx_t_rfc;
                    `CSR_ADDR_T_REF_MIN: index = idx_t_ref_min;
                    `CSR_ADDR_T_RP:      index = idx_t_rp;
                    `CSR_ADDR_T_RRD:     index = idx_t_rrd;
                    `CSR_ADDR_T_WRP:     index = idx_t_wrp;
                    `CSR_ADDR_T_XSR:     index = idx_t_xsr;
                    `CSR_ADDR_T_DAL:     index = idx_t_dal;
                    `CSR_ADDR_T_DPL:     index = idx_t_dpl;
                    `CSR_ADDR_T_MRD:     index = idx_t_mrd;
                    `CSR_ADDR_T_RDL:     index = idx_t_rdl;
                    default:             bank  = bank_none;  // Unmapped or dropped
                endcase
            end
        endcase
    end

    assign sel = '{wr: trans_start & write, bank: bank, index: index, wdata: writedata};

    always_comb begin
        case (bank)
            bank_mode:   bank_rdata = mode_rdata;
            bank_timing: bank_rdata = timing_rdata;
            default:     bank_rdata = '0;
        endcase
    end

    // --------------------------------------------------
    // Ack and registered read data
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trans_dly <= 1'b0;
            ack       <= 1'b0;
            readdata  <= '0;
        end else begin
            trans_dly <= trans;
            ack       <= trans_start;                       // Fixed one cycle latency
            if (trans_start && !write) begin
                readdata <= bank_rdata;
            end else begin
                readdata <= '0;                             // Zero outside the ack cycle
            end
        end
    end

endmodule

/* src/sdram_csr_mode_regs.sv */
`timescale 1ns/1ns

module sdram_csr_mode_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  sdram_csr_pkg::csr_sel_t  sel,
    output sdram_csr_pkg::csr_word_t mode_rdata,
    output sdram_csr_pkg::csr_mode_t mode_cfg
);

    import sdram_csr_pkg::*;

    csr_word_t   ctrl_reg;
    csr_opmode_u opmode_reg;
    csr_word_t   cfg_reg;
    logic        wr_en;

    assign wr_en = sel.wr && (sel.bank == bank_mode);

    // --------------------------------------------------
    // Register writes
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_reg        <= '0;
            opmode_reg.word <= '0;
            cfg_reg         <= '0;
        end else if (wr_en) begin
            case (sel.index)
                idx_ctrl:   ctrl_reg        <= sel.wdata;
                idx_opmode: opmode_reg.word <= sel.wdata;   // Whole word through word view
                idx_config: cfg_reg         <= sel.wdata;
                default:    ;
            endcase
        end
    end

    // Read-back returns words as written
    always_comb begin
        case (sel.index)
            idx_ctrl:   mode_rdata = ctrl_reg;
            idx_opmode: mode_rdata = opmode_reg.word;
            idx_config: mode_rdata = cfg_reg;
            default:    mode_rdata = '0;
        endcase
    end

    // --------------------------------------------------
    // Field views for the command sequencer
    // --------------------------------------------------
    assign mode_cfg = '{
        start:           ctrl_reg[0],
        self_refresh:    ctrl_reg[1],
        opmode:          opmode_reg.field,
        prechg_after_rd: cfg_reg[0],
        ctrl_word:       ctrl_reg,
        cfg_word:        cfg_reg
    };

endmodule

/* src/sdram_csr_timing_regs.sv */
`timescale 1ns/1ns

`include "sdram_csr_cfg.svh"

module sdram_csr_timing_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  sdram_csr_pkg::csr_sel_t    sel,
    output sdram_csr_pkg::csr_word_t   timing_rdata,
    output sdram_csr_pkg::csr_timing_t timing_cfg
);

    import sdram_csr_pkg::*;

    // Datasheet derived values cut to field width
    localparam csr_timing_t timing_rst = '{
        t_dly_rst: `CSR_W_T_DLY_RST'(`CSR_RST_T_DLY_RST),
        t_rasmin:  `CSR_W_T_RASMIN'(`CSR_RST_T_RASMIN),
        t_rasmax:  `CSR_W_T_RASMAX'(`CSR_RST_T_RASMAX),
        t_rc:      `CSR_W_T_RC'(`CSR_RST_T_RC),
        t_rcd:     `CSR_W_T_RCD'(`CSR_RST_T_RCD),
        t_ref:     `CSR_W_T_REF'(`CSR_RST_T_REF),
        t_rfc:     `CSR_W_T_RFC'(`CSR_RST_T_RFC),
        t_ref_min: `CSR_W_T_REF_MIN'(`CSR_RST_T_REF_MIN),
        t_rp:      `CSR_W_T_RP'(`CSR_RST_T_RP),
        t_rrd:     `CSR_W_T_RRD'(`CSR_RST_T_RRD),
        t_wrp:     `CSR_W_T_WRP'(`CSR_RST_T_WRP),
        t_xsr:     `CSR_W_T_XSR'(`CSR_RST_T_XSR),
        t_dal:     `CSR_W_T_DAL'(`CSR_RST_T_DAL),
        t_dpl:     `CSR_W_T_DPL'(`CSR_RST_T_DPL),
        t_mrd:     `CSR_W_T_MRD'(`CSR_RST_T_MRD),
        t_rdl:     `CSR_W_T_RDL'(`CSR_RST_T_RDL)
    };

    csr_timing_t timing_reg;
    logic        wr_en;

    assign wr_en = sel.wr && (sel.bank == bank_timing);

    // --------------------------------------------------
    // Register writes, low bits of the bus word only
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timing_reg <= timing_rst;
        end else if (wr_en) begin
            case (sel.index)
                idx_t_dly_rst: timing_reg.t_dly_rst <= sel.wdata[`CSR_W_T_DLY_RST-1:0];
                idx_t_rasmin:  timing_reg.t_rasmin  <= sel.wdata[`CSR_W_T_RASMIN-1:0];
                idx_t_rasmax:  timing_reg.t_rasmax  <= sel.wdata[`CSR_W_T_RASMAX-1:0];
                idx_t_rc:      timing_reg.t_rc      <= sel.wdata[`CSR_W_T_RC-1:0];
                idx_t_rcd:     timing_reg.t_rcd     <= sel.wdata[`CSR_W_T_RCD-1:0];
                idx_t_ref:     timing_reg.t_ref     <= sel.wdata[`CSR_W_T_REF-1:0];
                idx_t_rfc:     timing_reg.t_rfc     <= sel.wdata[`CSR_W_T_RFC-1:0];
                idx_t_ref_min: timing_reg.t_ref_min <= sel.wdata[`CSR_W_T_REF_MIN-1:0];
                idx_t_rp:      timing_reg.t_rp      <= sel.wdata[`CSR_W_T_RP-1:0];
                idx_t_rrd:     timing_reg.t_rrd     <= sel.wdata[`CSR_W_T_RRD-1:0];
                idx_t_wrp:     timing_reg.t_wrp     <= sel.wdata[`CSR_W_T_WRP-1:0];
                idx_t_xsr:     timing_reg.t_xsr     <= sel.wdata[`CSR_W_T_XSR-1:0];
                idx_t_dal:     timing_reg.t_dal     <= sel.wdata[`CSR_W_T_DAL-1:0];
                idx_t_dpl:     timing_reg.t_dpl     <= sel.wdata[`CSR_W_T_DPL-1:0];
                idx_t_mrd:     timing_reg.t_mrd     <= sel.wdata[`CSR_W_T_MRD-1:0];
                idx_t_rdl:     timing_reg.t_rdl     <= sel.wdata[`CSR_W_T_RDL-1:0];
                default:       ;
            endcase
        end
    end

    // --------------------------------------------------
    // Read-back, zero extended
    // --------------------------------------------------
    always_comb begin
        case (sel.index)
            idx_t_dly_rst: timing_rdata = csr_word_t'(timing_reg.t_dly_rst);
            idx_t_rasmin:  timing_rdata = csr_word_t'(timing_reg.t_rasmin);
            idx_t_rasmax:  timing_rdata = csr_word_t'(timing_reg.t_rasmax);
            idx_t_rc:      timing_rdata = csr_word_t'(timing_reg.t_rc);
            idx_t_rcd:     timing_rdata = csr_word_t'(timing_reg.t_rcd);
            idx_t_ref:     timing_rdata = csr_word_t'(timing_reg.t_ref);
            idx_t_rfc:     timing_rdata = csr_word_t'(timing_reg.t_rfc);
            idx_t_ref_min: timing_rdata = csr_word_t'(timing_reg.t_ref_min);
            idx_t_rp:      timing_rdata = csr_word_t'(timing_reg.t_rp);
            idx_t_rrd:     timing_rdata = csr_word_t'(timing_reg.t_rrd);
            idx_t_wrp:     timing_rdata = csr_word_t'(timing_reg.t_wrp);
            idx_t_xsr:     timing_rdata = csr_word_t'(timing_reg.t_xsr);
            idx_t_dal:     timing_rdata = csr_word_t'(timing_reg.t_dal);
            idx_t_dpl:     timing_rdata = csr_word_t'(timing_reg.t_dpl);
            idx_t_mrd:     timing_rdata = csr_word_t'(timing_reg.t_mrd);
            idx_t_rdl:     timing_rdata = csr_word_t'(timing_reg.t_rdl);
            default:       timing_rdata = '0;
        endcase
    end

    assign timing_cfg = timing_reg;

endmodule

/* src/sdram_csr.sv */
`timescale 1ns/1ns

module sdram_csr #(
    parameter int addr_width = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [addr_width-1:0]      address,
    input  sdram_csr_pkg::csr_word_t   writedata,
    input  logic                       strobe,
    input  logic                       cycle,
    input  logic                       write,
    output sdram_csr_pkg::csr_word_t   readdata,
    output logic                       ack,
    output sdram_csr_pkg::csr_mode_t   mode_cfg,
    output sdram_csr_pkg::csr_timing_t timing_cfg
);

    import sdram_csr_pkg::*;

    csr_sel_t  sel;                                         // Decoded access to both banks
    csr_word_t mode_rdata;
    csr_word_t timing_rdata;

    // --------------------------------------------------
    // Bus control and register banks
    // --------------------------------------------------
    sdram_csr_bus #(
        .addr_width(addr_width)
    ) u_bus (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .writedata   (writedata),
        .strobe      (strobe),
        .cycle       (cycle),
        .write       (write),
        .mode_rdata  (mode_rdata),
        .timing_rdata(timing_rdata),
        .sel         (sel),
        .readdata    (readdata),
        .ack         (ack)
    );

    sdram_csr_mode_regs u_mode_regs (
        .clk       (clk),
        .reset     (reset),
        .sel       (sel),
        .mode_rdata(mode_rdata),
        .mode_cfg  (mode_cfg)
    );

    sdram_csr_timing_regs u_timing_regs (
        .clk         (clk),
        .reset       (reset),
        .sel         (sel),
        .timing_rdata(timing_rdata),
        .timing_cfg  (timing_cfg)
    );

endmodule

/* verification/sdram_csr_properties.sv */
`timescale 1ns/1ns

module sdram_csr_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     strobe,
    input logic                     cycle,
    input logic                     ack,
    input sdram_csr_pkg::csr_word_t readdata
);

    logic trans_q;
    logic start;
    int   late_fails     = 0;
    int   spurious_fails = 0;
    int   rdata_fails    = 0;
    int   fail_count;                                       // Read by the testbench

    // --------------------------------------------------
    // Transfer start seen from the bus pins
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            trans_q <= 1'b0;
        end else begin
            trans_q <= strobe & cycle;
        end
    end

    assign start      = strobe & cycle & ~trans_q;          // First cycle of a transfer
    assign fail_count = late_fails + spurious_fails + rdata_fails;

    ack_after_start: assert property (@(posedge clk) disable iff (reset) start |=> ack)
        else begin
            late_fails++;
            $error("ack missing one cycle after transfer start");
        end

    ack_needs_start: assert property (@(posedge clk) disable iff (reset) ack |-> $past(start))
        else begin
            spurious_fails++;
            $error("ack without a transfer start one cycle before");
        end

    rdata_zero_idle: assert property (@(posedge clk) disable iff (reset) !ack |-> readdata == '0)
        else begin
            rdata_fails++;
            $error("readdata not zero outside the ack cycle");
        end

endmodule

bind sdram_csr_bus sdram_csr_properties props (
    .clk     (clk),
    .reset   (reset),
    .strobe  (strobe),
    .cycle   (cycle),
    .ack     (ack),
    .readdata(readdata)
);

/* verification/sdram_csr_tb.sv */
`timescale 1ns/1ns

module sdram_csr_tb;

    import sdram_csr_pkg::*;

    localparam int clk_period  = 8;
    localparam int n_transfers = 98;                        // Bus accesses over all tests
    localparam int ack_timeout = 8;
    localparam int watchdog_ns = (n_transfers * 4 + 4 + 60) * clk_period;

    // --------------------------------------------------
    // Register map, field widths and reset counts
    // --------------------------------------------------
    localparam logic [15:0] t_addr [16] = '{
        16'h20, 16'h64, 16'h68, 16'h6c, 16'h70, 16'h74, 16'h78, 16'h7c,
        16'h80, 16'h84, 16'h88, 16'h8c, 16'ha0, 16'ha4, 16'hb8, 16'hc0
    };
    localparam int t_width [16] = '{20, 8, 20, 8, 8, 20, 8, 16, 8, 8, 8, 8, 4, 4, 4, 4};
    localparam int t_rst [16] = '{
        100000, 37, 120000, 60, 15, 64000, 66, 7813, 15, 14, 14, 67, 4, 2, 2, 2
    };
    localparam logic [15:0] m_addr [3] = '{16'h00, 16'h04, 16'h08};
    localparam logic [15:0] bad_addr [6] = '{16'h24, 16'h0c, 16'h90, 16'hc4, 16'h1020, 16'h8004};

    logic        clk;
    logic        reset;
    logic [15:0] address;
    csr_word_t   writedata;
    logic        strobe;
    logic        cycle;
    logic        write;
    csr_word_t   readdata;
    logic        ack;
    csr_mode_t   mode_cfg;
    csr_timing_t timing_cfg;

    csr_word_t t_exp [16];                                  // Expected timing contents
    csr_word_t m_exp [3];                                   // Expected ctrl, opmode, config
    int        checks;
    int        errors;
    int        test_checks;
    int        test_errors;
    integer    seed;

    sdram_csr UUT (
        .clk       (clk),
        .reset     (reset),
        .address   (address),
        .writedata (writedata),
        .strobe    (strobe),
        .cycle     (cycle),
        .write     (write),
        .readdata  (readdata),
        .ack       (ack),
        .mode_cfg  (mode_cfg),
        .timing_cfg(timing_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Test failed");
        $finish;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic csr_word_t field_mask(input int width);
        return (32'd1 << width) - 32'd1;
    endfunction

    function automatic csr_word_t timing_field(input csr_timing_t t, input int i);
        case (i)
            0:       return csr_word_t'(t.t_dly_rst);
            1:       return csr_word_t'(t.t_rasmin);
            2:       return csr_word_t'(t.t_rasmax);
            3:       return csr_word_t'(t.t_rc);
            4:       return csr_word_t'(t.t_rcd);
            5:       return csr_word_t'(t.t_ref);
            6:       return csr_word_t'(t.t_rfc);
            7:       return csr_word_t'(t.t_ref_min);
            8:       return csr_word_t'(t.t_rp);
            9:       return csr_word_t'(t.t_rrd);
            10:      return csr_word_t'(t.t_wrp);
            11:      return csr_word_t'(t.t_xsr);
            12:      return csr_word_t'(t.t_dal);
            13:      return csr_word_t'(t.t_dpl);
            14:      return csr_word_t'(t.t_mrd);
            15:      return csr_word_t'(t.t_rdl);
            default: return 32'd0;
        endcase
    endfunction

    task automatic check_word(input csr_word_t got, input csr_word_t exp, input string msg);
        checks++;
        test_checks++;
        assert (got == exp) else begin
            $display("FAILED %0t: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // One transfer, returns once ack has been seen
    task automatic bus_access(input logic [15:0] addr, input logic wr, input csr_word_t wdata,
                              output csr_word_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        address   <= addr;
        writedata <= wdata;
        write     <= wr;
        strobe    <= 1'b1;
        cycle     <= 1'b1;
        @(negedge clk);
        while (!ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            $display("No ack from DUT within %0d cycles for address %h", ack_timeout, addr);
            errors++;
            test_errors++;
        end
        rdata = readdata;                                   // Valid in the ack cycle
        @(posedge clk);
        strobe <= 1'b0;
        cycle  <= 1'b0;
        write  <= 1'b0;
    endtask

    task automatic bus_write(input logic [15:0] addr, input csr_word_t wdata);
        csr_word_t unused_rdata;
        bus_access(addr, 1'b1, wdata, unused_rdata);
    endtask

    task automatic bus_read(input logic [15:0] addr, output csr_word_t rdata);
        bus_access(addr, 1'b0, 32'd0, rdata);
    endtask

    task automatic check_all_regs(input string when);
        csr_word_t rdata;
        for (int i = 0; i < 3; i++) begin
            bus_read(m_addr[i], rdata);
            check_word(rdata, m_exp[i], $sformatf("%s, read of %h", when, m_addr[i]));
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(t_addr[i], rdata);
            check_word(rdata, t_exp[i], $sformatf("%s, read of %h", when, t_addr[i]));
            check_word(timing_field(timing_cfg, i), t_exp[i],
                       $sformatf("%s, timing_cfg field %0d", when, i));
        end
    endtask

    // Opmode field positions, lowest bits first
    task automatic check_mode_fields();
        csr_word_t op;
        op = m_exp[1];
        check_word(csr_word_t'(mode_cfg.start), csr_word_t'(m_exp[0][0]), "start");
        check_word(csr_word_t'(mode_cfg.self_refresh), csr_word_t'(m_exp[0][1]), "self_refresh");
        check_word(csr_word_t'(mode_cfg.prechg_after_rd), csr_word_t'(m_exp[2][0]), "prechg");
        check_word(mode_cfg.ctrl_word, m_exp[0], "ctrl_word");
        check_word(mode_cfg.cfg_word, m_exp[2], "cfg_word");
        check_word(csr_word_t'(mode_cfg.opmode.burst_len), csr_word_t'(op[2:0]), "burst_len");
        check_word(csr_word_t'(mode_cfg.opmode.burst_type), csr_word_t'(op[3]), "burst_type");
        check_word(csr_word_t'(mode_cfg.opmode.cas_latency), csr_word_t'(op[6:4]), "cas_latency");
        check_word(csr_word_t'(mode_cfg.opmode.operation_mode), csr_word_t'(op[8:7]), "op_mode");
        check_word(csr_word_t'(mode_cfg.opmode.wr_burst_mode), csr_word_t'(op[9]), "wr_burst");
        check_word(csr_word_t'(mode_cfg.opmode.a_reserved), csr_word_t'(op[12:10]), "a_res");
        check_word(csr_word_t'(mode_cfg.opmode.ba_reserved), csr_word_t'(op[14:13]), "ba_res");
        check_word(csr_word_t'(mode_cfg.opmode.reserved), csr_word_t'(op[31:15]), "reserved");
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        csr_word_t rdata;
        csr_word_t wdata;
        int        ack_count;
        seed        = 80;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        reset     <= 1'b1;
        address   <= 16'h0;
        writedata <= 32'd0;
        strobe    <= 1'b0;
        cycle     <= 1'b0;
        write     <= 1'b0;
        for (int i = 0; i < 3; i++) m_exp[i] = 32'd0;
        for (int i = 0; i < 16; i++) t_exp[i] = csr_word_t'(t_rst[i]);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        check_word(csr_word_t'(ack), 32'd0, "ack after reset");
        check_word(csr_word_t'(mode_cfg.start), 32'd0, "start after reset");
        check_word(csr_word_t'(mode_cfg.self_refresh), 32'd0, "self_refresh after reset");
        check_all_regs("after reset");
        end_test("reset values");

        for (int r = 0; r < 2; r++) begin
            for (int i = 0; i < 3; i++) begin
                m_exp[i] = $random(seed);
                bus_write(m_addr[i], m_exp[i]);
            end
            for (int i = 0; i < 3; i++) begin
                bus_read(m_addr[i], rdata);
                check_word(rdata, m_exp[i], $sformatf("mode read of %h", m_addr[i]));
            end
            check_mode_fields();
        end
        end_test("mode registers");

        for (int i = 0; i < 16; i++) begin
            wdata = $random(seed);
            bus_write(t_addr[i], wdata);
            t_exp[i] = wdata & field_mask(t_width[i]);      // Only the field width is kept
        end
        for (int i = 0; i < 16; i++) begin
            bus_read(t_addr[i], rdata);
            check_word(rdata, t_exp[i], $sformatf("timing read of %h", t_addr[i]));
            check_word(timing_field(timing_cfg, i), t_exp[i], $sformatf("timing_cfg %0d", i));
        end
        end_test("timing registers");

        for (int i = 0; i < 6; i++) begin
            wdata = $random(seed);
            bus_write(bad_addr[i], wdata);
            bus_read(bad_addr[i], rdata);
            check_word(rdata, 32'd0, $sformatf("read of unmapped %h", bad_addr[i]));
        end
        check_all_regs("after unmapped writes");
        end_test("unmapped addresses");

        // Strobe held for several cycles
        ack_count = 0;
        @(posedge clk);
        address <= m_addr[1];
        write   <= 1'b0;
        strobe  <= 1'b1;
        cycle   <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            if (ack) ack_count++;
        end
        @(posedge clk);
        strobe <= 1'b0;
        cycle  <= 1'b0;
        check_word(csr_word_t'(ack_count), 32'd1, "acks for held strobe");
        bus_read(t_addr[0], rdata);                         // Back to back, one idle cycle
        check_word(rdata, t_exp[0], "back to back read 1");
        bus_read(t_addr[7], rdata);
        check_word(rdata, t_exp[7], "back to back read 2");
        bus_read(m_addr[0], rdata);
        check_word(rdata, m_exp[0], "back to back read 3");
        end_test("bus handshake");

        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, UUT.u_bus.props.fail_count);
        if (errors == 0 && UUT.u_bus.props.fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
src/sdram_csr_pkg.sv
src/sdram_csr_bus.sv
src/sdram_csr_mode_regs.sv
src/sdram_csr_timing_regs.sv
src/sdram_csr.sv
verification/sdram_csr_properties.sv
verification/sdram_csr_tb.sv

/* Makefile */
# Verilator flow for the SDRAM CSR block

VERILATOR   ?= verilator
TOP         ?= sdram_csr_tb
RTL_TOP     ?= sdram_csr
FILELIST    ?= all.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
